// File: dv/decode_stimulus.txt
// act instr flush rwe rsel rdata lwe ldata fwe fdata rst lr_bi fl_bi | expected:
// imm rd1 rd2 ctrl sel lr fl  (action 1 drives and checks, action 0 ends the list)
// register writes and read back
1 78000000 0 1 01 11111111 0 0 0 0 0 0 0 0 0 0 17800 0 0 0
1 78021000 0 1 1D DEADBEEF 0 0 0 0 0 0 0 0 11111111 11111111 17800 21 0 0
1 783BD000 0 1 1E AAAAAAAA 0 0 0 0 0 0 0 0 DEADBEEF DEADBEEF 17800 3BD 0 0
1 783DE000 0 1 1F 55555555 0 0 0 0 0 0 0 0 0 0 17800 3DE 0 0
1 783FF000 0 1 00 12345678 0 0 0 0 0 0 0 0 0 0 17800 3FF 0 0
1 78000000 0 0 00 0 0 0 0 0 0 0 0 0 0 0 17800 0 0 0
// bypass on the same cycle
1 780A1000 0 1 05 CAFEF00D 0 0 0 0 0 0 0 0 CAFEF00D 11111111 17800 A1 0 0
1 78022000 0 1 02 0000BEEF 0 0 0 0 0 0 0 0 11111111 0000BEEF 17800 22 0 0
// register ALU forms
1 00C22000 0 0 0 0 0 0 0 0 0 0 0 0 11111111 0000BEEF 10011 C22 0 0
1 113DF000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1101B 13DF 0 0
1 218BD000 0 0 0 0 0 0 0 0 0 0 0 0 CAFEF00D DEADBEEF 12011 18BD 0 0
1 287E1000 0 0 0 0 0 0 0 0 0 0 0 0 0 11111111 12813 7E1 0 0
1 3085E000 0 0 0 0 0 0 0 0 0 0 0 0 0000BEEF 0 13019 85E 0 0
1 41C3E000 0 0 0 0 0 0 0 0 0 0 0 0 11111111 0 14019 1C3E 0 0
1 4A041000 0 0 0 0 0 0 0 0 0 0 0 0 0000BEEF 11111111 14811 2041 0 0
1 527A5000 0 0 0 0 0 0 0 0 0 0 0 0 DEADBEEF CAFEF00D 15011 27A5 0 0
// immediates, negative short and zero extended long
1 08C20800 0 0 0 0 0 0 0 0 0 0 0 FFFFF800 11111111 0 811 C20 0 0
1 193C07FF 0 0 0 0 0 0 0 0 0 0 0 7FF 0 0 1819 13C0 0 0
1 397E2000 0 0 0 0 0 0 0 0 0 0 0 0 0 0000BEEF 13813 17E2 0 0
1 59841000 0 0 0 0 0 0 0 0 0 0 0 0 0000BEEF 11111111 158B1 1841 0 0
1 61CAABCD 0 0 0 0 0 0 0 0 0 0 0 0000ABCD CAFEF00D 0 60B1 1CAA 0 0
1 683C2000 0 0 0 0 0 0 0 0 0 0 0 0 0 0000BEEF 16988 3C2 0 0
1 70028001 0 0 0 0 0 0 0 0 0 0 0 00008001 11111111 0 7180 28 0 0
// branches and jumps
1 803C5000 0 0 0 0 0 0 0 0 0 0 0 0 0 CAFEF00D 1844A 3C5 0 0
1 88022000 0 0 0 0 0 0 0 0 0 0 0 0 11111111 0000BEEF 18C42 22 0 0
1 90000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 19442 0 0 0
1 983A1000 0 0 0 0 0 0 0 0 0 0 0 0 DEADBEEF 11111111 19C42 3A1 0 0
1 A0001234 0 0 0 0 0 0 0 0 0 0 0 060048D0 0 11111111 A240 1 0 0
1 A83C0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1AA48 3C0 0 0
1 B0003FFF 0 0 0 0 0 0 0 0 0 0 0 0600FFFC 0 0 B244 3 0 0
1 F8020000 0 0 0 0 0 0 0 0 0 0 0 0 11111111 0 1F800 20 0 0
// unused opcodes give all ones
1 B8021000 0 0 0 0 0 0 0 0 0 0 0 FFFFFFFF 0 0 3FFFF 7FFF 0 0
1 D8000000 0 0 0 0 0 0 0 0 0 0 0 FFFFFFFF 0 0 3FFFF 7FFF 0 0
// flush turns any instruction into a NOP
1 00C22000 1 0 0 0 0 0 0 0 0 0 0 0 11111111 0000BEEF 17800 22 0 0
1 00C22000 0 0 0 0 0 0 0 0 0 0 0 0 11111111 0000BEEF 10011 C22 0 0
1 B8021000 1 0 0 0 0 0 0 0 0 0 0 0 11111111 11111111 17800 21 0 0
1 B0003FFF 1 0 0 0 0 0 0 0 0 0 0 0 0 0 17800 3 0 0
1 B0003FFF 0 0 0 0 0 0 0 0 0 0 0 0600FFFC 0 0 B244 3 0 0
// LR and FL writes, restore wins
1 78000000 0 0 0 0 1 00001000 1 2 0 0 0 0 0 0 17800 0 0 0
1 78000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 17800 0 00001000 2
1 78000000 0 0 0 0 1 22222222 1 3 1 0000ABCC 1 0 0 0 17800 0 00001000 2
1 78000000 0 0 0 0 1 0600FFFC 0 0 0 0 0 0 0 0 17800 0 0000ABCC 1
1 78000000 0 0 0 0 0 0 1 3 0 0 0 0 0 0 17800 0 0600FFFC 1
1 78000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 17800 0 0600FFFC 3
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: dv/tb_decode_stage.sv
// testbench for the decode stage; replays dv/decode_stimulus.txt step by step and checks every output
`timescale 1ns/1ps

module tb_decode_stage;
	import decode_pkg::*;

	localparam int clk_period  = 8;
	localparam int step_words  = 20;
	localparam int max_steps   = 64;
	localparam int cycle_limit = 20;

	logic        clk;
	logic        rst_n;
	word_t       instr;
	logic        flush;
	logic        reg_wrt_en;
	reg_idx_t    reg_wrt_sel;
	word_t       reg_wrt_data;
	logic        lr_wrt_en;
	word_t       lr_wrt_data;
	logic        fl_wrt_en;
	flags_t      fl_wrt_data;
	logic        restore;
	word_t       lr_before_int;
	flags_t      fl_before_int;

	word_t       reg_1_data;
	word_t       reg_2_data;
	word_t       imm;
	word_t       lr;
	flags_t      fl;
	alu_src_t    alu_src;
	opcode_t     alu_op;
	logic        branch;
	logic        jump;
	logic        mem_wrt;
	logic        mem_en;
	result_sel_t result_sel;
	logic        dst_wrt_en;
	reg_idx_t    dst_sel;
	reg_idx_t    src1_sel;
	reg_idx_t    src2_sel;
	logic        lr_read;
	logic        lr_write;
	logic        fl_read;
	logic        fl_write;

	// flat image of the stimulus file with step_words entries per step
	logic [31:0] stim [0:max_steps*step_words-1];
	int          num_steps;
	int          checks;
	int          errors;
	logic [31:0] ctrl_word;
	logic [31:0] sel_word;

	decode_stage decode_stage_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.flush         (flush),
		.reg_wrt_en    (reg_wrt_en),
		.reg_wrt_sel   (reg_wrt_sel),
		.reg_wrt_data  (reg_wrt_data),
		.lr_wrt_en     (lr_wrt_en),
		.lr_wrt_data   (lr_wrt_data),
		.fl_wrt_en     (fl_wrt_en),
		.fl_wrt_data   (fl_wrt_data),
		.restore       (restore),
		.lr_before_int (lr_before_int),
		.fl_before_int (fl_before_int),
		.reg_1_data    (reg_1_data),
		.reg_2_data    (reg_2_data),
		.imm           (imm),
		.lr            (lr),
		.fl            (fl),
		.alu_src       (alu_src),
		.alu_op        (alu_op),
		.branch        (branch),
		.jump          (jump),
		.mem_wrt       (mem_wrt),
		.mem_en        (mem_en),
		.result_sel    (result_sel),
		.dst_wrt_en    (dst_wrt_en),
		.dst_sel       (dst_sel),
		.src1_sel      (src1_sel),
		.src2_sel      (src2_sel),
		.lr_read       (lr_read),
		.lr_write      (lr_write),
		.fl_read       (fl_read),
		.fl_write      (fl_write)
	);

	// control strobes packed in the same order as the stimulus file's ctrl column
	assign ctrl_word = {14'd0, alu_src, alu_op, branch, jump, mem_wrt, mem_en, result_sel,
		dst_wrt_en, lr_read, lr_write, fl_read, fl_write};
	assign sel_word  = {17'd0, dst_sel, src1_sel, src2_sel};

	initial begin
		clk = 1'b0;
		forever #(clk_period/2) clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic apply_step(input int base);
		instr         = stim[base+1];
		flush         = stim[base+2][0];
		reg_wrt_en    = stim[base+3][0];
		reg_wrt_sel   = stim[base+4][4:0];
		reg_wrt_data  = stim[base+5];
		lr_wrt_en     = stim[base+6][0];
		lr_wrt_data   = stim[base+7];
		fl_wrt_en     = stim[base+8][0];
		fl_wrt_data   = stim[base+9][1:0];
		restore       = stim[base+10][0];
		lr_before_int = stim[base+11];
		fl_before_int = stim[base+12][1:0];
	endtask

	task automatic check_step(input int base);
		compare_value("imm", stim[base+13], imm);
		compare_value("reg_1_data", stim[base+14], reg_1_data);
		compare_value("reg_2_data", stim[base+15], reg_2_data);
		compare_value("controls", stim[base+16], ctrl_word);
		compare_value("selects", stim[base+17], sel_word);
		compare_value("lr", stim[base+18], lr);
		compare_value("fl", stim[base+19], 32'(fl));
	endtask

	// run length follows from the number of steps in the file, counted before reset ends
	initial begin
		int limit_ns;
		@(posedge rst_n);
		limit_ns = (num_steps * cycle_limit + 2) * clk_period;
		#(limit_ns);
		$display("timeout: the stimulus did not finish within %0d ns", limit_ns);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int base;
		instr         = 32'h7800_0000;
		flush         = 1'b0;
		reg_wrt_en    = 1'b0;
		reg_wrt_sel   = '0;
		reg_wrt_data  = '0;
		lr_wrt_en     = 1'b0;
		lr_wrt_data   = '0;
		fl_wrt_en     = 1'b0;
		fl_wrt_data   = '0;
		restore       = 1'b0;
		lr_before_int = '0;
		fl_before_int = '0;
		rst_n         = 1'b0;
		checks        = 0;
		errors        = 0;
		num_steps     = 0;

		$readmemh("dv/decode_stimulus.txt", stim);
		// action 0 ends the list
		while (num_steps < max_steps && stim[num_steps*step_words] === 32'd1)
			num_steps++;
		if (num_steps == 0) begin
			$display("no steps could be read from the stimulus file");
			errors++;
		end

		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;

		for (int s = 0; s < num_steps; s++) begin
			base = s * step_words;
			@(posedge clk);
			#1;
			apply_step(base);
			#(clk_period - 2);
			check_step(base);
		end

		$display("decode stage run: %0d steps, %0d checks, %0d errors", num_steps, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: logic/decode_pkg.sv
// shared types, opcodes and instruction field positions for the decode stage; import with decode_pkg::*
package decode_pkg;

	localparam int word_w = 32;

	typedef logic [word_w-1:0] word_t;
	typedef logic [4:0]        reg_idx_t;
	typedef logic [1:0]        flags_t;
	typedef logic [1:0]        alu_src_t;
	typedef logic [1:0]        result_sel_t;

	// opcode space, note RIN sits at the very top and 23..30 are unused
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		ADDI,
		SUB,
		SUBI,
		AND,
		OR,
		XOR,
		NEG,
		SLL,
		SLR,
		SAR,
		LD,
		LDI,
		ST,
		STI,
		NOP  = 5'd15,
		BEQ  = 5'd16,
		BNE,
		BON,
		BNN,
		J,
		JR,
		JAL  = 5'd22,
		RIN  = 5'd31
	} opcode_t;

	// alu operand source
	localparam alu_src_t alu_src_imm  = 2'd0;
	localparam alu_src_t alu_src_reg2 = 2'd1;
	localparam alu_src_t alu_src_err  = 2'd3;

	// writeback source
	localparam result_sel_t result_alu = 2'd0;
	localparam result_sel_t result_mem = 2'd1;
	localparam result_sel_t result_pc  = 2'd2;
	localparam result_sel_t result_err = 2'd3;

	// registers with a special role
	localparam reg_idx_t reg_zero = 5'd0;
	localparam reg_idx_t reg_lr   = 5'd30;
	localparam reg_idx_t reg_fl   = 5'd31;

	// upper half of every jump target, where instruction memory starts
	localparam logic [15:0] imem_base = 16'h0600;

	// instruction fields
	localparam int op_msb      = 31;
	localparam int op_lsb      = 27;
	localparam int dst_msb     = 26;
	localparam int dst_lsb     = 22;
	localparam int src1_msb    = 21;
	localparam int src1_lsb    = 17;
	localparam int src2_msb    = 16;
	localparam int src2_lsb    = 12;
	localparam int imm_short_w = 12;
	localparam int imm_long_w  = 16;
	localparam int jump_w      = 14;

endpackage

// File: logic/decode_stage.sv
// decode stage top; ties the instruction decoder to the register file and the LR/FL registers
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  word_t       instr,
	input  logic        flush,
	// writeback port
	input  logic        reg_wrt_en,
	input  reg_idx_t    reg_wrt_sel,
	input  word_t       reg_wrt_data,
	// special register writes
	input  logic        lr_wrt_en,
	input  word_t       lr_wrt_data,
	input  logic        fl_wrt_en,
	input  flags_t      fl_wrt_data,
	// interrupt return
	input  logic        restore,
	input  word_t       lr_before_int,
	input  flags_t      fl_before_int,
	output word_t       reg_1_data,
	output word_t       reg_2_data,
	output word_t       imm,
	output word_t       lr,
	output flags_t      fl,
	output alu_src_t    alu_src,
	output opcode_t     alu_op,
	output logic        branch,
	output logic        jump,
	output logic        mem_wrt,
	output logic        mem_en,
	output result_sel_t result_sel,
	output logic        dst_wrt_en,
	output reg_idx_t    dst_sel,
	output reg_idx_t    src1_sel,
	output reg_idx_t    src2_sel,
	output logic        lr_read,
	output logic        lr_write,
	output logic        fl_read,
	output logic        fl_write
);

	instr_decoder decoder_inst (
		.instr      (instr),
		.flush      (flush),
		.imm        (imm),
		.alu_src    (alu_src),
		.alu_op     (alu_op),
		.branch     (branch),
		.jump       (jump),
		.mem_wrt    (mem_wrt),
		.mem_en     (mem_en),
		.result_sel (result_sel),
		.dst_wrt_en (dst_wrt_en),
		.dst_sel    (dst_sel),
		.src1_sel   (src1_sel),
		.src2_sel   (src2_sel),
		.lr_read    (lr_read),
		.lr_write   (lr_write),
		.fl_read    (fl_read),
		.fl_write   (fl_write)
	);

	// read indices come from the decoded source fields
	reg_file_bypass reg_file_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd1_sel  (src1_sel),
		.rd2_sel  (src2_sel),
		.wr_en    (reg_wrt_en),
		.wr_sel   (reg_wrt_sel),
		.wr_data  (reg_wrt_data),
		.rd1_data (reg_1_data),
		.rd2_data (reg_2_data)
	);

	special_regs special_regs_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.lr_wrt_en     (lr_wrt_en),
		.lr_wrt_data   (lr_wrt_data),
		.fl_wrt_en     (fl_wrt_en),
		.fl_wrt_data   (fl_wrt_data),
		.restore       (restore),
		.lr_before_int (lr_before_int),
		.fl_before_int (fl_before_int),
		.lr            (lr),
		.fl            (fl)
	);

endmodule

// File: logic/instr_decoder.sv
// combinational opcode decoder; turns one instruction into the immediate and the pipeline control strobes
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; (
	input  word_t       instr,
	input  logic        flush,
	output word_t       imm,
	output alu_src_t    alu_src,
	output opcode_t     alu_op,
	output logic        branch,
	output logic        jump,
	output logic        mem_wrt,
	output logic        mem_en,
	output result_sel_t result_sel,
	output logic        dst_wrt_en,
	output reg_idx_t    dst_sel,
	output reg_idx_t    src1_sel,
	output reg_idx_t    src2_sel,
	output logic        lr_read,
	output logic        lr_write,
	output logic        fl_read,
	output logic        fl_write
);

	opcode_t  op;
	reg_idx_t dst_field;
	reg_idx_t src1_field;
	reg_idx_t src2_field;
	word_t    imm_short;
	word_t    imm_long;
	word_t    jump_target;
	logic     lr_in1;
	logic     lr_in2;
	logic     fl_in1;
	logic     fl_in2;

	// a squashed instruction decodes exactly like a NOP
	assign op = flush ? NOP : opcode_t'(instr[op_msb:op_lsb]);

	assign dst_field  = instr[dst_msb:dst_lsb];
	assign src1_field = instr[src1_msb:src1_lsb];
	assign src2_field = instr[src2_msb:src2_lsb];

	// immediate forms
	assign imm_short   = {{(word_w-imm_short_w){instr[imm_short_w-1]}}, instr[imm_short_w-1:0]};
	assign imm_long    = {{(word_w-imm_long_w){1'b0}}, instr[imm_long_w-1:0]};
	// byte address, so two zero bits at the bottom
	assign jump_target = {imem_base, instr[jump_w-1:0], 2'b00};

	// source indices that point at LR or FL
	assign lr_in1 = (src1_field == reg_lr);
	assign lr_in2 = (src2_field == reg_lr);
	assign fl_in1 = (src1_field == reg_fl);
	assign fl_in2 = (src2_field == reg_fl);

	always_comb begin
		imm        = '0;
		alu_src    = alu_src_reg2;
		alu_op     = op;
		branch     = 1'b0;
		jump       = 1'b0;
		mem_wrt    = 1'b0;
		mem_en     = 1'b0;
		result_sel = result_alu;
		dst_wrt_en = 1'b0;
		dst_sel    = reg_zero;
		src1_sel   = src1_field;
		src2_sel   = src2_field;
		lr_read    = 1'b0;
		lr_write   = 1'b0;
		fl_read    = 1'b0;
		// most instructions update the flags
		fl_write   = 1'b1;

		case (op)
			// two register operands
			ADD, SUB, AND, OR, XOR, SLL, SLR, SAR: begin
				dst_wrt_en = 1'b1;
				dst_sel    = dst_field;
				lr_read    = lr_in1 || lr_in2;
				fl_read    = fl_in1 || fl_in2;
			end
			ADDI, SUBI: begin
				alu_src    = alu_src_imm;
				imm        = imm_short;
				dst_wrt_en = 1'b1;
				dst_sel    = dst_field;
				lr_read    = lr_in1;
				fl_read    = fl_in1;
			end
			NEG: begin
				dst_wrt_en = 1'b1;
				dst_sel    = dst_field;
				lr_read    = lr_in1;
				fl_read    = fl_in1;
			end
			LD: begin
				mem_en     = 1'b1;
				result_sel = result_mem;
				dst_wrt_en = 1'b1;
				dst_sel    = dst_field;
				lr_read    = lr_in1;
				fl_read    = fl_in1;
			end
			// absolute address, no base register
			LDI: begin
				alu_src    = alu_src_imm;
				imm        = imm_long;
				mem_en     = 1'b1;
				result_sel = result_mem;
				dst_wrt_en = 1'b1;
				dst_sel    = dst_field;
			end
			ST, STI: begin
				if (op == STI) begin
					alu_src = alu_src_imm;
					imm     = imm_long;
				end
				mem_en   = 1'b1;
				mem_wrt  = 1'b1;
				lr_read  = lr_in1;
				fl_read  = fl_in1;
				fl_write = 1'b0;
			end
			// conditional branches test the flags
			BEQ, BNE, BON, BNN: begin
				branch     = 1'b1;
				result_sel = result_pc;
				lr_read    = lr_in1;
				fl_read    = 1'b1;
				fl_write   = 1'b0;
			end
			J, JAL: begin
				alu_src    = alu_src_imm;
				jump       = 1'b1;
				imm        = jump_target;
				result_sel = result_pc;
				lr_write   = (op == JAL);
				fl_write   = 1'b0;
			end
			JR: begin
				jump       = 1'b1;
				result_sel = result_pc;
				lr_read    = lr_in1;
				fl_read    = fl_in1;
				fl_write   = 1'b0;
			end
			NOP, RIN: begin
				fl_write = 1'b0;
			end
			// unused opcode, flag it with all ones everywhere
			default: begin
				imm        = '1;
				alu_src    = alu_src_err;
				alu_op     = RIN;
				branch     = 1'b1;
				jump       = 1'b1;
				mem_wrt    = 1'b1;
				mem_en     = 1'b1;
				result_sel = result_err;
				dst_wrt_en = 1'b1;
				dst_sel    = '1;
				src1_sel   = '1;
				src2_sel   = '1;
				lr_read    = 1'b1;
				lr_write   = 1'b1;
				fl_read    = 1'b1;
				fl_write   = 1'b1;
			end
		endcase
	end

endmodule

// File: logic/reg_file_bypass.sv
// general register file with two read ports, one write port and same-cycle write bypass
`timescale 1ns/1ps

module reg_file_bypass import decode_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rd1_sel,
	input  reg_idx_t rd2_sel,
	input  logic     wr_en,
	input  reg_idx_t wr_sel,
	input  word_t    wr_data,
	output word_t    rd1_data,
	output word_t    rd2_data
);

	// only 1..29 are real storage, 0/30/31 live elsewhere or read as zero
	word_t regs [reg_zero+1:reg_lr-1];
	logic  wr_ok;

	function automatic logic is_protected(reg_idx_t idx);
		return (idx == reg_zero) || (idx == reg_lr) || (idx == reg_fl);
	endfunction

	assign wr_ok = wr_en && !is_protected(wr_sel);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			for (int i = reg_zero + 1; i <= reg_lr - 1; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// read ports, the bypass returns data being written this cycle
	always_comb begin
		if (is_protected(rd1_sel))
			rd1_data = '0;
		else if (wr_ok && (wr_sel == rd1_sel))
			rd1_data = wr_data;
		else
			rd1_data = regs[rd1_sel];
	end

	always_comb begin
		if (is_protected(rd2_sel))
			rd2_data = '0;
		else if (wr_ok && (wr_sel == rd2_sel))
			rd2_data = wr_data;
		else
			rd2_data = regs[rd2_sel];
	end

endmodule

// File: logic/special_regs.sv
// link and flag registers, written by later stages and restored on return from interrupt
`timescale 1ns/1ps

module special_regs import decode_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   lr_wrt_en,
	input  word_t  lr_wrt_data,
	input  logic   fl_wrt_en,
	input  flags_t fl_wrt_data,
	input  logic   restore,
	input  word_t  lr_before_int,
	input  flags_t fl_before_int,
	output word_t  lr,
	output flags_t fl
);

	// restore wins over a normal write in the same cycle
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			lr <= '0;
			fl <= '0;
		end else if (restore) begin
			lr <= lr_before_int;
			fl <= fl_before_int;
		end else begin
			if (lr_wrt_en)
				lr <= lr_wrt_data;
			if (fl_wrt_en)
				fl <= fl_wrt_data;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_decode_stage \
	-o sim_decode_stage > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_decode_stage > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
	echo "failures found, see sim.log"
	exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi

echo "run passed"
exit 0

// File: tb.f
logic/decode_pkg.sv
logic/instr_decoder.sv
logic/reg_file_bypass.sv
logic/special_regs.sv
logic/decode_stage.sv
dv/tb_decode_stage.sv
